// File: Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --timescale 1ns/1ps
TOP       = issue_stage_tb
FILELIST  = issue_stage.f

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; echo "$$out" | grep -q "All checks passed"

clean:
	rm -rf obj_dir

// File: hdl/free_list.sv
module free_list (
    input  logic                          clk,
    input  logic                          reset,
    input  logic [issue_pkg::ISSUE_WIDTH-1:0] pop_i,
    output issue_pkg::phys_addr_t         pop_phys_o [issue_pkg::ISSUE_WIDTH],
    input  logic [issue_pkg::ISSUE_WIDTH-1:0] push_i,
    input  issue_pkg::phys_addr_t         push_phys_i [issue_pkg::ISSUE_WIDTH],
    output logic                          rename_ready_o
);
    import issue_pkg::*;

    phys_addr_t            fifo_q [FREE_ENTRIES];
    logic [FREE_PTR_W-1:0] head_q;
    logic [FREE_PTR_W-1:0] tail_q;
    logic [FREE_PTR_W:0]   count_q;

    logic [FREE_PTR_W-1:0] pop_total;
    logic [FREE_PTR_W-1:0] push_total;
    logic [FREE_PTR_W-1:0] push_idx [ISSUE_WIDTH];

    // ======================================================================
    // Lane offsets into the ring
    // ======================================================================

    // A lane takes the slot after every lower lane that also pops or pushes
    always_comb begin
        pop_total  = '0;
        push_total = '0;
        for (int k = 0; k < ISSUE_WIDTH; k++) begin
            pop_phys_o[k] = fifo_q[head_q + pop_total];
            push_idx[k]   = tail_q + push_total;
            pop_total     = pop_total + FREE_PTR_W'(pop_i[k]);
            push_total    = push_total + FREE_PTR_W'(push_i[k]);
        end
    end

    // Enough entries left for a full group
    assign rename_ready_o = (count_q >= (FREE_PTR_W+1)'(ISSUE_WIDTH));

    // ======================================================================
    // Ring state
    // ======================================================================

    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            head_q  <= '0;
            tail_q  <= '0;
            count_q <= (FREE_PTR_W+1)'(FREE_ENTRIES);
            // Starts full with every register above the architectural set
            for (int i = 0; i < FREE_ENTRIES; i++) begin
                fifo_q[i] <= phys_addr_t'(ARCH_REGS + i);
            end
        end else begin
            head_q  <= head_q + pop_total;
            tail_q  <= tail_q + push_total;
            count_q <= count_q - {1'b0, pop_total} + {1'b0, push_total};
            for (int k = 0; k < ISSUE_WIDTH; k++) begin
                if (push_i[k]) begin
                    fifo_q[push_idx[k]] <= push_phys_i[k];
                end
            end
        end
    end

endmodule

// File: hdl/issue_pipeline_regs.sv
module issue_pipeline_regs (
    input  logic                              clk,
    input  logic                              reset,
    input  logic                              flush_i,
    input  logic                              bubble_i,
    input  logic [issue_pkg::ISSUE_WIDTH-1:0] decode_valid_i,
    input  logic [issue_pkg::ISSUE_WIDTH-1:0] dispatch_ready_i,
    input  logic                              rename_ready_i,
    output logic [issue_pkg::ISSUE_WIDTH-1:0] decode_ready_o,
    output logic [issue_pkg::ISSUE_WIDTH-1:0] accept_o,
    input  issue_pkg::instr_t                 pc_i [issue_pkg::ISSUE_WIDTH],
    input  issue_pkg::op_class_e              op_class_i [issue_pkg::ISSUE_WIDTH],
    input  issue_pkg::phys_addr_t             rs1_phys_i [issue_pkg::ISSUE_WIDTH],
    input  issue_pkg::phys_addr_t             rs2_phys_i [issue_pkg::ISSUE_WIDTH],
    input  issue_pkg::phys_addr_t             rd_phys_i [issue_pkg::ISSUE_WIDTH],
    input  issue_pkg::arch_addr_t             rd_arch_i [issue_pkg::ISSUE_WIDTH],
    input  issue_pkg::phys_addr_t             old_rd_phys_i [issue_pkg::ISSUE_WIDTH],
    input  logic [issue_pkg::ISSUE_WIDTH-1:0] rd_we_i,
    output logic [issue_pkg::ISSUE_WIDTH-1:0] dispatch_valid_o,
    output issue_pkg::instr_t                 pc_o [issue_pkg::ISSUE_WIDTH],
    output issue_pkg::op_class_e              op_class_o [issue_pkg::ISSUE_WIDTH],
    output issue_pkg::phys_addr_t             rs1_phys_o [issue_pkg::ISSUE_WIDTH],
    output issue_pkg::phys_addr_t             rs2_phys_o [issue_pkg::ISSUE_WIDTH],
    output issue_pkg::phys_addr_t             rd_phys_o [issue_pkg::ISSUE_WIDTH],
    output issue_pkg::arch_addr_t             rd_arch_o [issue_pkg::ISSUE_WIDTH],
    output issue_pkg::phys_addr_t             old_rd_phys_o [issue_pkg::ISSUE_WIDTH],
    output logic [issue_pkg::ISSUE_WIDTH-1:0] rd_we_o
);
    import issue_pkg::*;

    logic stall_all;

    // ======================================================================
    // Handshake
    // ======================================================================

    assign stall_all = flush_i | bubble_i;

    // Per lane, dispatch room and a full group of free registers
    assign decode_ready_o = dispatch_ready_i & {ISSUE_WIDTH{rename_ready_i & ~stall_all}};
    assign accept_o       = decode_valid_i & decode_ready_o;

    // Valid is a pure one-cycle echo of the accept
    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            dispatch_valid_o <= '0;
        end else begin
            dispatch_valid_o <= accept_o;
        end
    end

    // ======================================================================
    // Payload registers
    // ======================================================================

    for (genvar k = 0; k < ISSUE_WIDTH; k++) begin : g_lane
        always_ff @(posedge clk) begin
            if (accept_o[k]) begin
                pc_o[k]          <= pc_i[k];
                op_class_o[k]    <= op_class_i[k];
                rs1_phys_o[k]    <= rs1_phys_i[k];
                rs2_phys_o[k]    <= rs2_phys_i[k];
                rd_phys_o[k]     <= rd_phys_i[k];
                rd_arch_o[k]     <= rd_arch_i[k];
                old_rd_phys_o[k] <= old_rd_phys_i[k];
                rd_we_o[k]       <= rd_we_i[k];
            end else if (stall_all || dispatch_ready_i[k]) begin
                // Empty slot. A lane held by dispatch keeps its payload
                pc_o[k]          <= '0;
                op_class_o[k]    <= OP_NONE;
                rs1_phys_o[k]    <= '0;
                rs2_phys_o[k]    <= '0;
                rd_phys_o[k]     <= '0;
                rd_arch_o[k]     <= '0;
                old_rd_phys_o[k] <= '0;
                rd_we_o[k]       <= 1'b0;
            end
        end
    end

endmodule

// File: hdl/issue_pkg.sv
package issue_pkg;

    // ======================================================================
    // Machine geometry
    // ======================================================================

    // Lanes renamed per cycle
    localparam int ISSUE_WIDTH = 2;

    localparam int DATA_WIDTH  = 32;
    localparam int ARCH_REGS   = 32;
    localparam int PHYS_REGS   = 64;

    // Registers beyond the architectural set start out free
    localparam int FREE_ENTRIES = PHYS_REGS - ARCH_REGS;

    localparam int ARCH_ADDR_W = $clog2(ARCH_REGS);
    localparam int PHYS_ADDR_W = $clog2(PHYS_REGS);
    localparam int FREE_PTR_W  = $clog2(FREE_ENTRIES);

    typedef logic [ARCH_ADDR_W-1:0] arch_addr_t;
    typedef logic [PHYS_ADDR_W-1:0] phys_addr_t;
    typedef logic [DATA_WIDTH-1:0]  instr_t;

    // ======================================================================
    // RV32I major opcodes
    // ======================================================================

    localparam logic [6:0] OPC_REG    = 7'b0110011;
    localparam logic [6:0] OPC_IMM    = 7'b0010011;
    localparam logic [6:0] OPC_LOAD   = 7'b0000011;
    localparam logic [6:0] OPC_STORE  = 7'b0100011;
    localparam logic [6:0] OPC_BRANCH = 7'b1100011;
    localparam logic [6:0] OPC_LUI    = 7'b0110111;
    localparam logic [6:0] OPC_JAL    = 7'b1101111;

    // Operation class handed to dispatch
    typedef enum logic [2:0] {
        OP_NONE   = 3'd0,
        OP_REG    = 3'd1,
        OP_IMM    = 3'd2,
        OP_LOAD   = 3'd3,
        OP_STORE  = 3'd4,
        OP_BRANCH = 3'd5,
        OP_LUI    = 3'd6,
        OP_JAL    = 3'd7
    } op_class_e;

endpackage

// File: hdl/issue_stage.sv
module issue_stage (
    input  logic                              clk,
    input  logic                              reset,
    input  logic                              flush_i,
    input  logic                              bubble_i,
    input  logic [issue_pkg::ISSUE_WIDTH-1:0] decode_valid_i,
    input  issue_pkg::instr_t                 instr_i [issue_pkg::ISSUE_WIDTH],
    input  issue_pkg::instr_t                 pc_i [issue_pkg::ISSUE_WIDTH],
    output logic [issue_pkg::ISSUE_WIDTH-1:0] decode_ready_o,
    input  logic [issue_pkg::ISSUE_WIDTH-1:0] commit_valid_i,
    input  issue_pkg::phys_addr_t             commit_free_phys_i [issue_pkg::ISSUE_WIDTH],
    input  logic [issue_pkg::ISSUE_WIDTH-1:0] dispatch_ready_i,
    output logic [issue_pkg::ISSUE_WIDTH-1:0] dispatch_valid_o,
    output issue_pkg::instr_t                 pc_o [issue_pkg::ISSUE_WIDTH],
    output issue_pkg::op_class_e              op_class_o [issue_pkg::ISSUE_WIDTH],
    output issue_pkg::phys_addr_t             rs1_phys_o [issue_pkg::ISSUE_WIDTH],
    output issue_pkg::phys_addr_t             rs2_phys_o [issue_pkg::ISSUE_WIDTH],
    output issue_pkg::phys_addr_t             rd_phys_o [issue_pkg::ISSUE_WIDTH],
    output issue_pkg::arch_addr_t             rd_arch_o [issue_pkg::ISSUE_WIDTH],
    output issue_pkg::phys_addr_t             old_rd_phys_o [issue_pkg::ISSUE_WIDTH],
    output logic [issue_pkg::ISSUE_WIDTH-1:0] rd_we_o
);
    import issue_pkg::*;

    op_class_e              op_class [ISSUE_WIDTH];
    arch_addr_t             rs1_arch [ISSUE_WIDTH];
    arch_addr_t             rs2_arch [ISSUE_WIDTH];
    arch_addr_t             rd_arch [ISSUE_WIDTH];
    logic [ISSUE_WIDTH-1:0] rd_we;
    phys_addr_t             rs1_phys [ISSUE_WIDTH];
    phys_addr_t             rs2_phys [ISSUE_WIDTH];
    phys_addr_t             rd_phys [ISSUE_WIDTH];
    phys_addr_t             old_rd_phys [ISSUE_WIDTH];
    logic [ISSUE_WIDTH-1:0] accept;
    logic                   rename_ready;

    // ======================================================================
    // Decode, rename, register toward dispatch
    // ======================================================================

    for (genvar k = 0; k < ISSUE_WIDTH; k++) begin : g_dec
        rv32i_decoder u_decoder (
            .instr_i    (instr_i[k]),
            .op_class_o (op_class[k]),
            .rs1_o      (rs1_arch[k]),
            .rs2_o      (rs2_arch[k]),
            .rd_o       (rd_arch[k]),
            .rd_we_o    (rd_we[k])
        );
    end

    register_alias_table u_rat (
        .clk                (clk),
        .reset              (reset),
        .accept_i           (accept),
        .rs1_arch_i         (rs1_arch),
        .rs2_arch_i         (rs2_arch),
        .rd_arch_i          (rd_arch),
        .rd_we_i            (rd_we),
        .rs1_phys_o         (rs1_phys),
        .rs2_phys_o         (rs2_phys),
        .rd_phys_o          (rd_phys),
        .old_rd_phys_o      (old_rd_phys),
        .commit_valid_i     (commit_valid_i),
        .commit_free_phys_i (commit_free_phys_i),
        .rename_ready_o     (rename_ready)
    );

    issue_pipeline_regs u_regs (
        .clk              (clk),
        .reset            (reset),
        .flush_i          (flush_i),
        .bubble_i         (bubble_i),
        .decode_valid_i   (decode_valid_i),
        .dispatch_ready_i (dispatch_ready_i),
        .rename_ready_i   (rename_ready),
        .decode_ready_o   (decode_ready_o),
        .accept_o         (accept),
        .pc_i             (pc_i),
        .op_class_i       (op_class),
        .rs1_phys_i       (rs1_phys),
        .rs2_phys_i       (rs2_phys),
        .rd_phys_i        (rd_phys),
        .rd_arch_i        (rd_arch),
        .old_rd_phys_i    (old_rd_phys),
        .rd_we_i          (rd_we),
        .dispatch_valid_o (dispatch_valid_o),
        .pc_o             (pc_o),
        .op_class_o       (op_class_o),
        .rs1_phys_o       (rs1_phys_o),
        .rs2_phys_o       (rs2_phys_o),
        .rd_phys_o        (rd_phys_o),
        .rd_arch_o        (rd_arch_o),
        .old_rd_phys_o    (old_rd_phys_o),
        .rd_we_o          (rd_we_o)
    );

endmodule

// File: hdl/register_alias_table.sv
module register_alias_table (
    input  logic                              clk,
    input  logic                              reset,
    input  logic [issue_pkg::ISSUE_WIDTH-1:0] accept_i,
    input  issue_pkg::arch_addr_t             rs1_arch_i [issue_pkg::ISSUE_WIDTH],
    input  issue_pkg::arch_addr_t             rs2_arch_i [issue_pkg::ISSUE_WIDTH],
    input  issue_pkg::arch_addr_t             rd_arch_i [issue_pkg::ISSUE_WIDTH],
    input  logic [issue_pkg::ISSUE_WIDTH-1:0] rd_we_i,
    output issue_pkg::phys_addr_t             rs1_phys_o [issue_pkg::ISSUE_WIDTH],
    output issue_pkg::phys_addr_t             rs2_phys_o [issue_pkg::ISSUE_WIDTH],
    output issue_pkg::phys_addr_t             rd_phys_o [issue_pkg::ISSUE_WIDTH],
    output issue_pkg::phys_addr_t             old_rd_phys_o [issue_pkg::ISSUE_WIDTH],
    input  logic [issue_pkg::ISSUE_WIDTH-1:0] commit_valid_i,
    input  issue_pkg::phys_addr_t             commit_free_phys_i [issue_pkg::ISSUE_WIDTH],
    output logic                              rename_ready_o
);
    import issue_pkg::*;

    phys_addr_t             map_q [ARCH_REGS];
    logic [ISSUE_WIDTH-1:0] alloc;
    phys_addr_t             new_phys [ISSUE_WIDTH];

    // One new register per accepted lane that writes a destination
    assign alloc = accept_i & rd_we_i;

    free_list u_free_list (
        .clk            (clk),
        .reset          (reset),
        .pop_i          (alloc),
        .pop_phys_o     (new_phys),
        .push_i         (commit_valid_i),
        .push_phys_i    (commit_free_phys_i),
        .rename_ready_o (rename_ready_o)
    );

    // ======================================================================
    // Lookup with in-group bypass
    // ======================================================================

    // Start from the committed map, then let each older lane in the group
    // override with its fresh register. The youngest older writer wins.
    always_comb begin
        for (int k = 0; k < ISSUE_WIDTH; k++) begin
            rs1_phys_o[k]    = map_q[rs1_arch_i[k]];
            rs2_phys_o[k]    = map_q[rs2_arch_i[k]];
            old_rd_phys_o[k] = map_q[rd_arch_i[k]];
            for (int j = 0; j < k; j++) begin
                if (alloc[j] && (rd_arch_i[j] == rs1_arch_i[k])) begin
                    rs1_phys_o[k] = new_phys[j];
                end
                if (alloc[j] && (rd_arch_i[j] == rs2_arch_i[k])) begin
                    rs2_phys_o[k] = new_phys[j];
                end
                if (alloc[j] && (rd_arch_i[j] == rd_arch_i[k])) begin
                    old_rd_phys_o[k] = new_phys[j];
                end
            end
            rd_phys_o[k] = rd_we_i[k] ? new_phys[k] : '0;
        end
    end

    // ======================================================================
    // Map update
    // ======================================================================

    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            // Identity map, arch i lives in phys i
            for (int i = 0; i < ARCH_REGS; i++) begin
                map_q[i] <= phys_addr_t'(i);
            end
        end else begin
            // Later lanes come last so they win on a shared rd
            for (int k = 0; k < ISSUE_WIDTH; k++) begin
                if (alloc[k]) begin
                    map_q[rd_arch_i[k]] <= new_phys[k];
                end
            end
        end
    end

endmodule

// File: hdl/rv32i_decoder.sv
module rv32i_decoder (
    input  issue_pkg::instr_t     instr_i,
    output issue_pkg::op_class_e  op_class_o,
    output issue_pkg::arch_addr_t rs1_o,
    output issue_pkg::arch_addr_t rs2_o,
    output issue_pkg::arch_addr_t rd_o,
    output logic                  rd_we_o
);
    import issue_pkg::*;

    logic [6:0] opcode;
    logic       reads_rs1;
    logic       reads_rs2;
    logic       has_rd;

    assign opcode = instr_i[6:0];

    // Only the class and the register usage matter at this stage
    always_comb begin
        op_class_o = OP_NONE;
        reads_rs1  = 1'b0;
        reads_rs2  = 1'b0;
        has_rd     = 1'b0;
        case (opcode)
            OPC_REG: begin
                op_class_o = OP_REG;
                reads_rs1  = 1'b1;
                reads_rs2  = 1'b1;
                has_rd     = 1'b1;
            end
            OPC_IMM, OPC_LOAD: begin
                op_class_o = (opcode == OPC_IMM) ? OP_IMM : OP_LOAD;
                reads_rs1  = 1'b1;
                has_rd     = 1'b1;
            end
            OPC_STORE, OPC_BRANCH: begin
                op_class_o = (opcode == OPC_STORE) ? OP_STORE : OP_BRANCH;
                reads_rs1  = 1'b1;
                reads_rs2  = 1'b1;
            end
            OPC_LUI, OPC_JAL: begin
                op_class_o = (opcode == OPC_LUI) ? OP_LUI : OP_JAL;
                has_rd     = 1'b1;
            end
            default: op_class_o = OP_NONE;
        endcase
    end

    // Unused fields read as x0 so they never alias a live mapping
    assign rs1_o = reads_rs1 ? instr_i[19:15] : '0;
    assign rs2_o = reads_rs2 ? instr_i[24:20] : '0;
    assign rd_o  = has_rd    ? instr_i[11:7]  : '0;

    // Writes to x0 need no physical register
    assign rd_we_o = has_rd && (rd_o != '0);

endmodule

// File: issue_stage.f
+incdir+tests
hdl/issue_pkg.sv
hdl/rv32i_decoder.sv
hdl/free_list.sv
hdl/register_alias_table.sv
hdl/issue_pipeline_regs.sv
hdl/issue_stage.sv
tests/issue_stage_tb.sv

// File: tests/issue_model.svh
`ifndef ISSUE_MODEL_SVH
`define ISSUE_MODEL_SVH

// Expected dispatch slot for one lane
typedef struct {
    logic       valid;
    instr_t     pc;
    op_class_e  op_class;
    phys_addr_t rs1;
    phys_addr_t rs2;
    phys_addr_t rd_phys;
    arch_addr_t rd_arch;
    phys_addr_t old_rd;
    logic       we;
} expect_t;

phys_addr_t model_map [ARCH_REGS];
phys_addr_t model_free [$];

// Identity map, free list holds every register above the architectural set
function automatic void model_reset();
    model_free.delete();
    for (int i = 0; i < ARCH_REGS; i++) begin
        model_map[i] = phys_addr_t'(i);
    end
    for (int i = ARCH_REGS; i < PHYS_REGS; i++) begin
        model_free.push_back(phys_addr_t'(i));
    end
endfunction

// Lanes are renamed one after another, so a younger lane sees the
// mapping an older lane just made
function automatic expect_t model_rename(input instr_t instr, input instr_t pc);
    expect_t    e;
    logic [6:0] opc;
    logic       src1;
    logic       src2;
    logic       dst;
    arch_addr_t rs1;
    arch_addr_t rs2;
    opc  = instr[6:0];
    src1 = opc inside {OPC_REG, OPC_IMM, OPC_LOAD, OPC_STORE, OPC_BRANCH};
    src2 = opc inside {OPC_REG, OPC_STORE, OPC_BRANCH};
    dst  = opc inside {OPC_REG, OPC_IMM, OPC_LOAD, OPC_LUI, OPC_JAL};
    case (opc)
        OPC_REG:    e.op_class = OP_REG;
        OPC_IMM:    e.op_class = OP_IMM;
        OPC_LOAD:   e.op_class = OP_LOAD;
        OPC_STORE:  e.op_class = OP_STORE;
        OPC_BRANCH: e.op_class = OP_BRANCH;
        OPC_LUI:    e.op_class = OP_LUI;
        OPC_JAL:    e.op_class = OP_JAL;
        default:    e.op_class = OP_NONE;
    endcase
    rs1       = src1 ? instr[19:15] : '0;
    rs2       = src2 ? instr[24:20] : '0;
    e.rd_arch = dst ? instr[11:7] : '0;
    e.we      = dst && (e.rd_arch != '0);
    e.valid   = 1'b1;
    e.pc      = pc;
    e.rs1     = model_map[rs1];
    e.rs2     = model_map[rs2];
    e.old_rd  = model_map[e.rd_arch];
    e.rd_phys = '0;
    if (e.we) begin
        e.rd_phys = model_free.pop_front();
        model_map[e.rd_arch] = e.rd_phys;
    end
    return e;
endfunction

`endif

// File: tests/issue_stage_tb.sv
module issue_stage_tb;
    timeunit 1ns;
    timeprecision 1ps;
    import issue_pkg::*;

    `include "issue_model.svh"

    localparam int PHASE_CYCLES = 600;
    // Four long phases, the short reset phase and some margin
    localparam int TIMEOUT_CYCLES = 4 * PHASE_CYCLES + 600;
    localparam logic [6:0] RAND_OPCODES [9] = '{OPC_REG, OPC_IMM, OPC_LOAD, OPC_STORE,
        OPC_BRANCH, OPC_LUI, OPC_JAL, 7'b0010111, 7'b0001111};

    logic                   clk;
    logic                   reset;
    logic                   flush_i;
    logic                   bubble_i;
    logic [ISSUE_WIDTH-1:0] decode_valid_i;
    instr_t                 instr_i [ISSUE_WIDTH];
    instr_t                 pc_i [ISSUE_WIDTH];
    logic [ISSUE_WIDTH-1:0] decode_ready_o;
    logic [ISSUE_WIDTH-1:0] commit_valid_i;
    phys_addr_t             commit_free_phys_i [ISSUE_WIDTH];
    logic [ISSUE_WIDTH-1:0] dispatch_ready_i;
    logic [ISSUE_WIDTH-1:0] dispatch_valid_o;
    instr_t                 pc_o [ISSUE_WIDTH];
    op_class_e              op_class_o [ISSUE_WIDTH];
    phys_addr_t             rs1_phys_o [ISSUE_WIDTH];
    phys_addr_t             rs2_phys_o [ISSUE_WIDTH];
    phys_addr_t             rd_phys_o [ISSUE_WIDTH];
    arch_addr_t             rd_arch_o [ISSUE_WIDTH];
    phys_addr_t             old_rd_phys_o [ISSUE_WIDTH];
    logic [ISSUE_WIDTH-1:0] rd_we_o;

    expect_t                exp_slot [ISSUE_WIDTH];
    logic [ISSUE_WIDTH-1:0] slot_known;
    phys_addr_t             pending [$];
    string                  test_name;
    int                     check_count;
    int                     error_count;
    int                     failed_tests;
    int                     cycle_count;
    int                     ready_low_cycles;

    issue_stage uut (.*);

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    initial begin
        cycle_count = 0;
        while (cycle_count < TIMEOUT_CYCLES) begin
            @(posedge clk);
            cycle_count++;
        end
        $display("Timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
        $display("Checks failed");
        $finish;
    end

    // ======================================================================
    // Checking
    // ======================================================================

    task automatic check_value(input string what, input logic [31:0] expected,
                               input logic [31:0] actual);
        check_count++;
        if (expected !== actual) begin
            error_count++;
            $display("ERROR %s %s: expected 0x%0h, actual 0x%0h",
                     test_name, what, expected, actual);
        end
    endtask

    // Outputs settled at the last rising edge, compare against the slots
    task automatic compare_outputs();
        string lane;
        for (int k = 0; k < ISSUE_WIDTH; k++) begin
            lane = $sformatf("lane%0d", k);
            check_value({lane, " valid"}, 32'(exp_slot[k].valid), 32'(dispatch_valid_o[k]));
            // Fresh, held and cleared payloads alike
            if (slot_known[k]) begin
                check_value({lane, " pc"}, exp_slot[k].pc, pc_o[k]);
                check_value({lane, " op_class"}, 32'(exp_slot[k].op_class), 32'(op_class_o[k]));
                check_value({lane, " rs1_phys"}, 32'(exp_slot[k].rs1), 32'(rs1_phys_o[k]));
                check_value({lane, " rs2_phys"}, 32'(exp_slot[k].rs2), 32'(rs2_phys_o[k]));
                check_value({lane, " rd_phys"}, 32'(exp_slot[k].rd_phys), 32'(rd_phys_o[k]));
                check_value({lane, " rd_arch"}, 32'(exp_slot[k].rd_arch), 32'(rd_arch_o[k]));
                check_value({lane, " old_rd"}, 32'(exp_slot[k].old_rd), 32'(old_rd_phys_o[k]));
                check_value({lane, " rd_we"}, 32'(exp_slot[k].we), 32'(rd_we_o[k]));
            end
            // The replaced register goes back once the ROB commits
            if (exp_slot[k].valid && exp_slot[k].we) begin
                pending.push_back(exp_slot[k].old_rd);
            end
        end
    endtask

    // Payload left behind by a flush or bubble
    function automatic expect_t empty_slot();
        expect_t e;
        e.valid    = 1'b0;
        e.pc       = '0;
        e.op_class = OP_NONE;
        e.rs1      = '0;
        e.rs2      = '0;
        e.rd_phys  = '0;
        e.rd_arch  = '0;
        e.old_rd   = '0;
        e.we       = 1'b0;
        return e;
    endfunction

    // ======================================================================
    // Stimulus
    // ======================================================================

    // Half the picks land on x0..x3 so lanes collide often
    function automatic arch_addr_t pick_reg();
        if ($urandom_range(0, 1) == 0) begin
            return arch_addr_t'($urandom_range(0, 3));
        end
        return arch_addr_t'($urandom_range(0, ARCH_REGS - 1));
    endfunction

    function automatic instr_t encode(input logic [6:0] opc, input int rd,
                                      input int rs1, input int rs2);
        return {7'd0, 5'(rs2), 5'(rs1), 3'd0, 5'(rd), opc};
    endfunction

    task automatic drive_random(input int ready_pct, input int stall_pct);
        int sel;
        for (int k = 0; k < ISSUE_WIDTH; k++) begin
            sel = $urandom_range(0, 8);
            instr_i[k]          = $urandom();
            instr_i[k][6:0]     = RAND_OPCODES[sel];
            instr_i[k][11:7]    = pick_reg();
            instr_i[k][19:15]   = pick_reg();
            instr_i[k][24:20]   = pick_reg();
            pc_i[k]             = $urandom();
            decode_valid_i[k]   = ($urandom_range(0, 9) < 8);
            dispatch_ready_i[k] = ($urandom_range(0, 99) < ready_pct);
        end
        flush_i  = ($urandom_range(0, 99) < stall_pct);
        bubble_i = ($urandom_range(0, 99) < stall_pct);
    endtask

    task automatic drive_commits(input int commit_pct);
        for (int k = 0; k < ISSUE_WIDTH; k++) begin
            commit_valid_i[k]     = 1'b0;
            commit_free_phys_i[k] = '0;
            if (pending.size() > 0 && $urandom_range(0, 99) < commit_pct) begin
                commit_valid_i[k]     = 1'b1;
                commit_free_phys_i[k] = pending.pop_front();
            end
        end
    endtask

    // Check ready, rename the accepted lanes, then wait for the next falling edge
    task automatic settle_and_predict();
        logic ready_model;
        #1;
        ready_model = (model_free.size() >= ISSUE_WIDTH) && !flush_i && !bubble_i;
        if (dispatch_ready_i != '0 && model_free.size() < ISSUE_WIDTH) begin
            ready_low_cycles++;
        end
        for (int k = 0; k < ISSUE_WIDTH; k++) begin
            check_value($sformatf("lane%0d decode_ready", k),
                        32'(dispatch_ready_i[k] & ready_model), 32'(decode_ready_o[k]));
            exp_slot[k].valid = 1'b0;
            if (decode_valid_i[k] && dispatch_ready_i[k] && ready_model) begin
                exp_slot[k]   = model_rename(instr_i[k], pc_i[k]);
                slot_known[k] = 1'b1;
            end else if (flush_i || bubble_i) begin
                exp_slot[k]   = empty_slot();
                slot_known[k] = 1'b1;
            end else if (dispatch_ready_i[k]) begin
                // An idle lane with dispatch room is not compared
                slot_known[k] = 1'b0;
            end
            // Held by dispatch, the payload stays as it was
        end
        // Returned registers join the tail behind this cycle's allocations
        for (int k = 0; k < ISSUE_WIDTH; k++) begin
            if (commit_valid_i[k]) begin
                model_free.push_back(commit_free_phys_i[k]);
            end
        end
        @(negedge clk);
    endtask

    task automatic run_phase(input string name, input int cycles, input int ready_pct,
                             input int stall_pct, input int commit_pct);
        test_name = name;
        for (int i = 0; i < cycles; i++) begin
            compare_outputs();
            drive_random(ready_pct, stall_pct);
            drive_commits(commit_pct);
            settle_and_predict();
        end
    endtask

    task automatic report_test(input int errors_before);
        if (error_count == errors_before) begin
            $display("test %s: PASS", test_name);
        end else begin
            failed_tests++;
            $display("test %s: FAIL, %0d errors", test_name, error_count - errors_before);
        end
    endtask

    // ======================================================================
    // Test sequence
    // ======================================================================

    initial begin
        int errors_before;
        void'($urandom(32'hbaca3cb9));
        reset            = 1'b0;
        flush_i          = 1'b0;
        bubble_i         = 1'b0;
        decode_valid_i   = '0;
        dispatch_ready_i = '0;
        commit_valid_i   = '0;
        for (int k = 0; k < ISSUE_WIDTH; k++) begin
            instr_i[k]            = '0;
            pc_i[k]               = '0;
            commit_free_phys_i[k] = '0;
            exp_slot[k].valid     = 1'b0;
        end
        slot_known       = '0;
        check_count      = 0;
        error_count      = 0;
        failed_tests     = 0;
        ready_low_cycles = 0;
        model_reset();
        repeat (2) @(posedge clk);
        @(negedge clk);
        reset = 1'b1;

        // Lane 1 reads x1 which lane 0 renames in the same group
        test_name     = "after_reset";
        errors_before = error_count;
        compare_outputs();
        dispatch_ready_i = '1;
        decode_valid_i   = '1;
        instr_i[0]       = encode(OPC_REG, 1, 2, 3);
        instr_i[1]       = encode(OPC_IMM, 2, 1, 0);
        pc_i[0]          = 32'h100;
        pc_i[1]          = 32'h104;
        settle_and_predict();
        compare_outputs();
        check_value("first rd", 32'd32, 32'(rd_phys_o[0]));
        check_value("second rd", 32'd33, 32'(rd_phys_o[1]));
        check_value("bypass rs1", 32'd32, 32'(rs1_phys_o[1]));
        check_value("untouched rs2", 32'd3, 32'(rs2_phys_o[0]));
        decode_valid_i = '0;
        settle_and_predict();
        report_test(errors_before);

        errors_before = error_count;
        run_phase("random_stream", PHASE_CYCLES, 100, 0, 60);
        report_test(errors_before);

        errors_before = error_count;
        run_phase("back_pressure", PHASE_CYCLES, 50, 0, 60);
        report_test(errors_before);

        // Starve the free list first, then let commits refill it
        errors_before    = error_count;
        ready_low_cycles = 0;
        run_phase("exhaustion", 80, 100, 0, 0);
        if (ready_low_cycles == 0) begin
            error_count++;
            $display("Free list never ran dry during exhaustion, decode_ready stayed high");
        end
        run_phase("exhaustion", PHASE_CYCLES - 80, 100, 0, 50);
        report_test(errors_before);

        errors_before = error_count;
        run_phase("flush_bubble", PHASE_CYCLES, 80, 12, 60);
        compare_outputs();
        report_test(errors_before);

        $display("Summary: 5 tests, %0d failed, %0d checks, %0d errors",
                 failed_tests, check_count, error_count);
        if (error_count == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule
